/* rtl/dcache_pkg.sv */
package dcache_pkg;

// CPU word and memory line geometry
localparam int word_w = 32;
localparam int line_w = 128;
localparam int offset_bits = 4; // Byte offset within one line

// Address bits above the line offset, stored whole as the tag
localparam int line_addr_w = word_w - offset_bits;

// One CPU word
typedef logic [word_w-1:0] word_t;

// Byte enables for one word
typedef logic [word_w/8-1:0] mask_t;

// One memory line
typedef logic [line_w-1:0] line_t;

// Line address, also the stored tag
typedef logic [line_addr_w-1:0] line_addr_t;

// Controller states
typedef enum logic [1:0] {
	idle,
	compare, // Tag lookup, and the response on a hit
	write_back, // Dirty victim goes out to memory
	fill
} ctrl_state_t;

endpackage : dcache_pkg

/* rtl/dcache_array.sv */
`timescale 1ns/1ps

// Register file with one entry per set
// The payload type is chosen by the instantiating module, so tags and lines share this block
module dcache_array #(
	parameter int set_bits = 3,
	parameter type entry_t = logic
) (
	input logic clk,
	input logic [set_bits-1:0] index,
	input logic load,
	input entry_t wdata,
	output entry_t rdata
);

localparam int num_sets = 2 ** set_bits;

entry_t entries [num_sets];

always_ff @(posedge clk) begin
	if (load)
		entries[index] <= wdata; // Written on the closing edge of the strobe cycle
end

// Lookup happens in the same cycle as the request
assign rdata = entries[index];

endmodule : dcache_array

/* rtl/dcache_datapath.sv */
`timescale 1ns/1ps

module dcache_datapath #(
	parameter int set_bits = 3
) (
	input logic clk,
	input logic rst_n,
	input dcache_pkg::word_t mem_addr,
	input dcache_pkg::word_t mem_wdata,
	input dcache_pkg::mask_t mem_wmask,
	input logic [1:0] load_tag,
	input logic [1:0] load_data,
	input logic [1:0] set_valid,
	input logic [1:0] set_dirty,
	input logic [1:0] clear_dirty,
	input logic load_lru,
	input logic addr_sel,
	input logic fill_sel,
	input dcache_pkg::line_t pmem_rdata,
	output logic hit,
	output logic [1:0] way_hit,
	output logic lru_way,
	output logic victim_dirty,
	output dcache_pkg::word_t mem_rdata,
	output dcache_pkg::word_t pmem_addr,
	output dcache_pkg::line_t pmem_wdata
);

localparam int num_sets = 2 ** set_bits;
localparam int byte_sel_bits = $clog2(dcache_pkg::word_w / 8);
localparam int word_sel_bits = dcache_pkg::offset_bits - byte_sel_bits;

logic [set_bits-1:0] index;
logic [word_sel_bits-1:0] word_sel;
dcache_pkg::line_addr_t req_line;

dcache_pkg::line_addr_t tag_out [2];
dcache_pkg::line_t data_out [2];
dcache_pkg::line_t hit_line;
dcache_pkg::line_t merged_line;
dcache_pkg::line_t line_wdata;

// Per-set state bits, one column per way
logic [num_sets-1:0][1:0] valid_bits;
logic [num_sets-1:0][1:0] dirty_bits;
logic [num_sets-1:0] lru_bits; // Names the least recently used way

assign req_line = mem_addr[dcache_pkg::word_w-1:dcache_pkg::offset_bits];
assign index = mem_addr[dcache_pkg::offset_bits +: set_bits];
assign word_sel = mem_addr[byte_sel_bits +: word_sel_bits];

for (genvar w = 0; w < 2; w++) begin : g_way
	dcache_array #(
		.set_bits(set_bits),
		.entry_t(dcache_pkg::line_addr_t)
	) tag_array (
		.clk(clk),
		.index(index),
		.load(load_tag[w]),
		.wdata(req_line),
		.rdata(tag_out[w])
	);

	dcache_array #(
		.set_bits(set_bits),
		.entry_t(dcache_pkg::line_t)
	) data_array (
		.clk(clk),
		.index(index),
		.load(load_data[w]),
		.wdata(line_wdata),
		.rdata(data_out[w])
	);

	assign way_hit[w] = valid_bits[index][w] && (tag_out[w] == req_line);
end

assign hit = |way_hit;
assign lru_way = lru_bits[index];
assign victim_dirty = valid_bits[index][lru_way] & dirty_bits[index][lru_way];

assign hit_line = way_hit[1] ? data_out[1] : data_out[0];
assign mem_rdata = hit_line[word_sel * dcache_pkg::word_w +: dcache_pkg::word_w];

// Only the enabled bytes of the addressed word change
always_comb begin
	merged_line = hit_line;
	for (int b = 0; b < dcache_pkg::word_w / 8; b++) begin
		if (mem_wmask[b])
			merged_line[word_sel * dcache_pkg::word_w + b * 8 +: 8] = mem_wdata[b * 8 +: 8];
	end
end

assign line_wdata = fill_sel ? pmem_rdata : merged_line;

// Write-back goes to where the victim came from, a fill to the request's line
assign pmem_addr = {addr_sel ? tag_out[lru_way] : req_line,
	{dcache_pkg::offset_bits{1'b0}}};
assign pmem_wdata = data_out[lru_way];

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		valid_bits <= '0;
		dirty_bits <= '0;
		lru_bits <= '0;
	end else begin
		for (int w = 0; w < 2; w++) begin
			if (set_valid[w])
				valid_bits[index][w] <= 1'b1;
			if (set_dirty[w])
				dirty_bits[index][w] <= 1'b1;
			else if (clear_dirty[w])
				dirty_bits[index][w] <= 1'b0;
		end
		if (load_lru)
			lru_bits[index] <= way_hit[0]; // The way that was not used becomes LRU
	end
end

endmodule : dcache_datapath

/* rtl/dcache_control.sv */
`timescale 1ns/1ps

module dcache_control (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input logic hit,
	input logic [1:0] way_hit,
	input logic lru_way,
	input logic victim_dirty,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic [1:0] load_tag,
	output logic [1:0] load_data,
	output logic [1:0] set_valid,
	output logic [1:0] set_dirty,
	output logic [1:0] clear_dirty,
	output logic load_lru,
	output logic addr_sel,
	output logic fill_sel
);

dcache_pkg::ctrl_state_t state;
dcache_pkg::ctrl_state_t next_state;

logic [1:0] lru_onehot;

// Victim and fill target are the same way
assign lru_onehot = lru_way ? 2'b10 : 2'b01;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		state <= dcache_pkg::idle;
	else
		state <= next_state;
end

always_comb begin
	next_state = state;
	unique case (state)
		dcache_pkg::idle: begin
			if (mem_read || mem_write)
				next_state = dcache_pkg::compare;
		end
		dcache_pkg::compare: begin
			if (hit)
				next_state = dcache_pkg::idle; // The CPU may follow up one cycle later
			else if (victim_dirty)
				next_state = dcache_pkg::write_back;
			else
				next_state = dcache_pkg::fill;
		end
		dcache_pkg::write_back: begin
			if (pmem_resp)
				next_state = dcache_pkg::fill;
		end
		dcache_pkg::fill: begin
			if (pmem_resp)
				next_state = dcache_pkg::compare; // Looks up again and now hits
		end
		default: next_state = dcache_pkg::idle;
	endcase
end

always_comb begin
	mem_resp = 1'b0;
	pmem_read = 1'b0;
	pmem_write = 1'b0;
	load_tag = 2'b00;
	load_data = 2'b00;
	set_valid = 2'b00;
	set_dirty = 2'b00;
	clear_dirty = 2'b00;
	load_lru = 1'b0;
	addr_sel = 1'b0;
	fill_sel = 1'b0;

	unique case (state)
		dcache_pkg::idle: begin
		end
		dcache_pkg::compare: begin
			if (hit) begin
				mem_resp = 1'b1;
				load_lru = 1'b1;
				if (mem_write) begin
					load_data = way_hit; // Merged line goes back into the hit way
					set_dirty = way_hit;
				end
			end else if (victim_dirty) begin
				pmem_write = 1'b1;
				addr_sel = 1'b1;
			end else begin
				pmem_read = 1'b1;
			end
		end
		dcache_pkg::write_back: begin
			pmem_write = 1'b1;
			addr_sel = 1'b1;
			if (pmem_resp)
				clear_dirty = lru_onehot;
		end
		dcache_pkg::fill: begin
			pmem_read = 1'b1;
			if (pmem_resp) begin
				// Line, tag and valid bit land on the same edge
				load_tag = lru_onehot;
				load_data = lru_onehot;
				set_valid = lru_onehot;
				fill_sel = 1'b1;
			end
		end
		default: begin
		end
	endcase
end

endmodule : dcache_control

/* rtl/dcache.sv */
`timescale 1ns/1ps

// Two-way set-associative write-back data cache
module dcache #(
	parameter int set_bits = 3
) (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input dcache_pkg::word_t mem_addr,
	input dcache_pkg::word_t mem_wdata,
	input dcache_pkg::mask_t mem_wmask,
	output dcache_pkg::word_t mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output dcache_pkg::word_t pmem_addr,
	output dcache_pkg::line_t pmem_wdata,
	input dcache_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

// Strobes from the controller
logic [1:0] load_tag;
logic [1:0] load_data;
logic [1:0] set_valid;
logic [1:0] set_dirty;
logic [1:0] clear_dirty;
logic load_lru;
logic addr_sel;
logic fill_sel;

// Lookup status back to the controller
logic hit;
logic [1:0] way_hit;
logic lru_way;
logic victim_dirty;

dcache_control control (
	.clk(clk),
	.rst_n(rst_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.pmem_resp(pmem_resp),
	.hit(hit),
	.way_hit(way_hit),
	.lru_way(lru_way),
	.victim_dirty(victim_dirty),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.load_tag(load_tag),
	.load_data(load_data),
	.set_valid(set_valid),
	.set_dirty(set_dirty),
	.clear_dirty(clear_dirty),
	.load_lru(load_lru),
	.addr_sel(addr_sel),
	.fill_sel(fill_sel)
);

dcache_datapath #(
	.set_bits(set_bits)
) datapath (
	.clk(clk),
	.rst_n(rst_n),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.mem_wmask(mem_wmask),
	.load_tag(load_tag),
	.load_data(load_data),
	.set_valid(set_valid),
	.set_dirty(set_dirty),
	.clear_dirty(clear_dirty),
	.load_lru(load_lru),
	.addr_sel(addr_sel),
	.fill_sel(fill_sel),
	.pmem_rdata(pmem_rdata),
	.hit(hit),
	.way_hit(way_hit),
	.lru_way(lru_way),
	.victim_dirty(victim_dirty),
	.mem_rdata(mem_rdata),
	.pmem_addr(pmem_addr),
	.pmem_wdata(pmem_wdata)
);

endmodule : dcache

/* tests/pmem_model.sv */
`timescale 1ns/1ps

// Line memory behind the cache, answering each request after a random delay
module pmem_model (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input dcache_pkg::word_t pmem_addr,
	input dcache_pkg::line_t pmem_wdata,
	output dcache_pkg::line_t pmem_rdata,
	output logic pmem_resp
);

localparam int num_lines = 256;

dcache_pkg::line_t lines [num_lines];
bit written [num_lines]; // Lines never written read back as the address pattern
logic busy;
int wait_cycles;
integer seed = 44;
logic [7:0] slot;

assign slot = pmem_addr[dcache_pkg::offset_bits +: 8];

function automatic dcache_pkg::word_t word_pattern(input dcache_pkg::word_t addr);
	return (addr * 32'h0001_0003) ^ 32'hc001_d00d;
endfunction

function automatic dcache_pkg::line_t line_pattern(input dcache_pkg::word_t line_base);
	dcache_pkg::line_t line;
	for (int w = 0; w < dcache_pkg::line_w / dcache_pkg::word_w; w++)
		line[w * dcache_pkg::word_w +: dcache_pkg::word_w] = word_pattern(line_base + w * 4);
	return line;
endfunction

always @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		busy <= 1'b0;
		wait_cycles <= 0;
		pmem_resp <= 1'b0;
		pmem_rdata <= '0;
	end else begin
		pmem_resp <= 1'b0;
		if (pmem_resp) begin
			busy <= 1'b0; // The cache moves on at this edge
		end else if (!busy && (pmem_read || pmem_write)) begin
			busy <= 1'b1;
			wait_cycles <= {$random(seed)} % 4;
		end else if (busy) begin
			if (wait_cycles == 0) begin
				pmem_resp <= 1'b1;
				if (pmem_write) begin
					lines[slot] <= pmem_wdata;
					written[slot] <= 1'b1;
				end else begin
					pmem_rdata <= written[slot] ? lines[slot] : line_pattern(pmem_addr);
				end
			end else begin
				wait_cycles <= wait_cycles - 1;
			end
		end
	end
end

endmodule : pmem_model

/* tests/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

localparam int set_bits = 3;
localparam int num_sets = 2 ** set_bits;
localparam int resp_timeout = 60;
localparam dcache_pkg::word_t base_addr = 32'h0004_2000;

logic clk;
logic rst_n;
logic mem_read;
logic mem_write;
dcache_pkg::word_t mem_addr;
dcache_pkg::word_t mem_wdata;
dcache_pkg::mask_t mem_wmask;
dcache_pkg::word_t mem_rdata;
logic mem_resp;
logic pmem_read;
logic pmem_write;
dcache_pkg::word_t pmem_addr;
dcache_pkg::line_t pmem_wdata;
dcache_pkg::line_t pmem_rdata;
logic pmem_resp;

integer seed = 44;

// Reference memory holds one word per entry over a 4 KB window
dcache_pkg::word_t ref_mem [1024];

// Shadow of the cache state
dcache_pkg::line_addr_t sh_tag [num_sets][2];
bit sh_valid [num_sets][2];
bit sh_dirty [num_sets][2];
bit sh_lru [num_sets];
int expected_reads = 0;
int expected_writes = 0;

// Memory traffic as seen on the bus
int pmem_reads = 0;
int pmem_writes = 0;
int read_requests = 0;
int write_requests = 0;
logic read_q;
logic write_q;
dcache_pkg::word_t wb_addr;
dcache_pkg::line_t wb_data;
dcache_pkg::word_t fill_addr;

dcache dut0 (
	.clk(clk),
	.rst_n(rst_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.mem_wmask(mem_wmask),
	.mem_rdata(mem_rdata),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_addr(pmem_addr),
	.pmem_wdata(pmem_wdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

pmem_model pmem0 (
	.clk(clk),
	.rst_n(rst_n),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_addr(pmem_addr),
	.pmem_wdata(pmem_wdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

always @(posedge clk) begin
	if (pmem_resp && pmem_write) begin
		pmem_writes <= pmem_writes + 1;
		wb_addr <= pmem_addr;
		wb_data <= pmem_wdata;
	end
	if (pmem_resp && pmem_read) begin
		pmem_reads <= pmem_reads + 1;
		fill_addr <= pmem_addr;
	end
end

// Each request is counted once where its strobe first rises
always @(posedge clk) begin
	read_q <= pmem_read;
	write_q <= pmem_write;
	if (pmem_read && !read_q)
		read_requests <= read_requests + 1;
	if (pmem_write && !write_q)
		write_requests <= write_requests + 1;
end

// Same address function as the memory model
function automatic dcache_pkg::word_t init_word(input dcache_pkg::word_t addr);
	return (addr * 32'h0001_0003) ^ 32'hc001_d00d;
endfunction

function automatic dcache_pkg::word_t merge_word(input dcache_pkg::word_t old_word,
		input dcache_pkg::word_t new_word, input dcache_pkg::mask_t mask);
	dcache_pkg::word_t result;
	result = old_word;
	for (int b = 0; b < 4; b++)
		if (mask[b])
			result[b * 8 +: 8] = new_word[b * 8 +: 8];
	return result;
endfunction

function automatic dcache_pkg::line_t line_from_ref(input dcache_pkg::line_addr_t line);
	dcache_pkg::line_t data;
	for (int w = 0; w < 4; w++)
		data[w * 32 +: 32] = ref_mem[{line[7:0], w[1:0]}];
	return data;
endfunction

task automatic check_equal(input logic [127:0] got, input logic [127:0] expected,
		input string what);
	if (got !== expected) begin
		$display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
		$display("Some tests failed");
		$fatal(1);
	end
endtask

task automatic report_hang(input string what);
	$display("The cache gave no response to the %s within %0d cycles", what, resp_timeout);
	$display("Some tests failed");
	$fatal(1);
endtask

// One CPU request is predicted on the shadow and then checked against the bus
task automatic access(input bit is_write, input dcache_pkg::word_t addr,
		input dcache_pkg::word_t wdata, input dcache_pkg::mask_t wmask);
	int set_idx;
	int way;
	int cycles;
	int reads_before;
	int writes_before;
	bit exp_hit;
	bit exp_wb;
	dcache_pkg::line_addr_t line;
	dcache_pkg::line_addr_t victim_line;
	dcache_pkg::line_t victim_data;
	set_idx = addr[dcache_pkg::offset_bits +: set_bits];
	line = addr[31:dcache_pkg::offset_bits];
	exp_hit = 1'b0;
	exp_wb = 1'b0;
	way = 0;
	for (int w = 0; w < 2; w++) begin
		if (sh_valid[set_idx][w] && sh_tag[set_idx][w] == line) begin
			exp_hit = 1'b1;
			way = w;
		end
	end
	if (!exp_hit) begin
		way = sh_lru[set_idx]; // Victim and fill target
		exp_wb = sh_valid[set_idx][way] && sh_dirty[set_idx][way];
		victim_line = sh_tag[set_idx][way];
		victim_data = line_from_ref(victim_line);
	end
	reads_before = pmem_reads;
	writes_before = pmem_writes;
	mem_read = !is_write;
	mem_write = is_write;
	mem_addr = addr;
	mem_wdata = wdata;
	mem_wmask = wmask;
	cycles = 0;
	@(negedge clk);
	while (!mem_resp) begin
		cycles++;
		if (cycles > resp_timeout)
			report_hang($sformatf("%s of address %h", is_write ? "write" : "read", addr));
		@(negedge clk);
	end
	if (!is_write)
		check_equal(mem_rdata, ref_mem[addr[11:2]], $sformatf("read data at %h", addr));
	check_equal(pmem_writes - writes_before, exp_wb, $sformatf("write-backs for %h", addr));
	check_equal(pmem_reads - reads_before, !exp_hit, $sformatf("fills for %h", addr));
	if (exp_wb) begin
		check_equal(wb_addr, {victim_line, 4'h0}, "write-back address");
		check_equal(wb_data, victim_data, "write-back line");
	end
	if (!exp_hit) begin
		check_equal(fill_addr, {line, 4'h0}, "fill address");
		sh_tag[set_idx][way] = line;
		sh_valid[set_idx][way] = 1'b1;
		sh_dirty[set_idx][way] = 1'b0;
		expected_reads++;
		expected_writes += exp_wb;
	end
	sh_lru[set_idx] = (way == 0); // The other way becomes least recently used
	if (is_write) begin
		ref_mem[addr[11:2]] = merge_word(ref_mem[addr[11:2]], wdata, wmask);
		sh_dirty[set_idx][way] = 1'b1;
	end
	@(posedge clk);
	#1;
	mem_read = 1'b0;
	mem_write = 1'b0;
endtask

initial begin
	dcache_pkg::word_t r;
	dcache_pkg::word_t addr;
	rst_n = 1'b0;
	mem_read = 1'b0;
	mem_write = 1'b0;
	mem_addr = '0;
	mem_wdata = '0;
	mem_wmask = '0;
	for (int i = 0; i < 1024; i++)
		ref_mem[i] = init_word(base_addr + i * 4);
	repeat (8) @(posedge clk);
	#1;
	rst_n = 1'b1;

	@(negedge clk);
	check_equal(mem_resp, 1'b0, "mem_resp after reset");
	check_equal(pmem_read, 1'b0, "pmem_read after reset");
	check_equal(pmem_write, 1'b0, "pmem_write after reset");
	@(posedge clk);
	#1;

	access(1'b0, base_addr + 32'h804, '0, '0); // Untouched line, one fill

	repeat (16) begin
		r = $random(seed);
		addr = base_addr + 32'h400 + {r[7:2], 2'b00};
		access(1'b1, addr, $random(seed), r[11:8]);
		access(1'b0, addr, '0, '0);
	end

	// Three lines of set 0 in rotation
	for (int round = 0; round < 3; round++) begin
		for (int k = 0; k < 3; k++)
			access(1'b1, base_addr + 32'hc00 + k * 32'h80 + round * 4, $random(seed), 4'hf);
		for (int k = 0; k < 3; k++)
			access(1'b0, base_addr + 32'hc00 + k * 32'h80 + round * 4, '0, '0);
	end

	// Every other line is used so four sets each see four lines
	repeat (400) begin
		r = $random(seed);
		addr = base_addr + r[3:0] * 32 + r[5:4] * 4;
		access(r[6], addr, $random(seed), r[10:7]);
	end
	check_equal(read_requests, expected_reads, "total fill requests");
	check_equal(write_requests, expected_writes, "total write-back requests");

	$display("All tests passed");
	$finish;
end

endmodule : dcache_tb

/* filelist.f */
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/dcache_datapath.sv
rtl/dcache_control.sv
rtl/dcache.sv
tests/pmem_model.sv
tests/dcache_tb.sv
